//--- logic/ddr2_pkg.sv
// DDR2 controller shared definitions
package ddr2_pkg;

  // ----------------------------------------------------------------------
  // geometry
  // ----------------------------------------------------------------------
  localparam int BA_BITS   = 3;
  localparam int ROW_BITS  = 13;
  localparam int COL_BITS  = 10;
  localparam int ADDR_BITS = 13;
  localparam int DQ_BITS   = 8;

  // ----------------------------------------------------------------------
  // timing, all in clk cycles
  // ----------------------------------------------------------------------
  localparam int T_CKE_WAIT = 20;
  localparam int T_RP       = 3;
  localparam int T_RFC      = 12;
  localparam int T_MRD      = 2;
  localparam int T_RCD      = 3;
  localparam int T_WR       = 3;
  localparam int WL         = 2;
  localparam int RL         = 3;
  localparam int T_REFI     = 400;

  // address pin that turns PRE into precharge-all
  localparam int A10_ALLPRE = 10;

  typedef logic [BA_BITS-1:0]                    bank_t;
  typedef logic [ROW_BITS-1:0]                   row_t;
  typedef logic [COL_BITS-1:0]                   col_t;
  typedef logic [ADDR_BITS-1:0]                  dram_addr_t;
  typedef logic [BA_BITS+ROW_BITS+COL_BITS-1:0]  axi_addr_t;
  typedef logic [7:0]                            burst_len_t;
  typedef logic [2*DQ_BITS-1:0]                  word_t;

  // BL4 sequential, CL3, write recovery 2
  localparam dram_addr_t MR_VALUE   = 13'h0232;
  // DLL on, full drive, Rtt 75 ohm
  localparam dram_addr_t EMR1_VALUE = 13'h0004;

  // {cs_n, ras_n, cas_n, we_n}
  typedef enum logic [3:0] {
    CMD_LMR   = 4'b0000,
    CMD_AREF  = 4'b0001,
    CMD_PRE   = 4'b0010,
    CMD_ACT   = 4'b0011,
    CMD_WRITE = 4'b0100,
    CMD_READ  = 4'b0101,
    CMD_NOP   = 4'b0111
  } dram_cmd_t;

  typedef enum logic [3:0] {
    ST_INIT,
    ST_IDLE,
    ST_REF_PRE,
    ST_REF_WAIT,
    ST_ACT_WAIT,
    ST_WRITE,
    ST_WR_RECOVER,
    ST_READ,
    ST_RD_DRAIN,
    ST_PRE_WAIT
  } ctrl_state_t;

  typedef enum logic [1:0] {
    INIT_CKE,
    INIT_ISSUE,
    INIT_WAIT,
    INIT_DONE
  } init_state_t;

endpackage

//--- logic/ddr2_init_seq.sv
// DDR2 power-up sequencer
module ddr2_init_seq (
  input  logic                 clk,
  input  logic                 rst_n,
  output ddr2_pkg::dram_cmd_t  init_cmd,
  output ddr2_pkg::bank_t      init_ba,
  output ddr2_pkg::dram_addr_t init_addr,
  output logic                 dram_cke,
  output logic                 init_end
);

  typedef logic [$clog2(ddr2_pkg::T_CKE_WAIT)-1:0] wait_t;

  ddr2_pkg::init_state_t state;
  wait_t                 wait_cnt;
  logic [3:0]            step;

  ddr2_pkg::dram_cmd_t   step_cmd;
  ddr2_pkg::bank_t       step_ba;
  ddr2_pkg::dram_addr_t  step_addr;
  wait_t                 step_wait;
  logic                  step_last;

  // ----------------------------------------------------------------------
  // command table, one entry per step
  // ----------------------------------------------------------------------
  always_comb begin
    step_cmd  = ddr2_pkg::CMD_LMR;
    step_ba   = '0;
    step_addr = '0;
    step_wait = wait_t'(ddr2_pkg::T_MRD - 1);
    step_last = 1'b0;
    case (step)
      4'd0, 4'd5: begin
        step_cmd                       = ddr2_pkg::CMD_PRE;
        step_addr[ddr2_pkg::A10_ALLPRE] = 1'b1;
        step_wait                      = wait_t'(ddr2_pkg::T_RP - 1);
      end
      // EMR2 and EMR3 stay at zero
      4'd1: step_ba = ddr2_pkg::bank_t'(2);
      4'd2: step_ba = ddr2_pkg::bank_t'(3);
      4'd3: begin
        step_ba   = ddr2_pkg::bank_t'(1);
        step_addr = ddr2_pkg::EMR1_VALUE;
      end
      4'd4: step_addr = ddr2_pkg::MR_VALUE;
      4'd6, 4'd7: begin
        step_cmd  = ddr2_pkg::CMD_AREF;
        step_wait = wait_t'(ddr2_pkg::T_RFC - 1);
      end
      default: begin
        // final mode register load
        step_addr = ddr2_pkg::MR_VALUE;
        step_last = 1'b1;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= ddr2_pkg::INIT_CKE;
      wait_cnt  <= wait_t'(ddr2_pkg::T_CKE_WAIT - 1);
      step      <= '0;
      init_cmd  <= ddr2_pkg::CMD_NOP;
      init_ba   <= '0;
      init_addr <= '0;
      dram_cke  <= 1'b0;
      init_end  <= 1'b0;
    end else begin
      case (state)
        ddr2_pkg::INIT_CKE: begin
          if (wait_cnt == '0) begin
            dram_cke <= 1'b1;
            state    <= ddr2_pkg::INIT_ISSUE;
          end else begin
            wait_cnt <= wait_cnt - 1'b1;
          end
        end
        ddr2_pkg::INIT_ISSUE: begin
          init_cmd  <= step_cmd;
          init_ba   <= step_ba;
          init_addr <= step_addr;
          wait_cnt  <= step_wait;
          state     <= ddr2_pkg::INIT_WAIT;
        end
        ddr2_pkg::INIT_WAIT: begin
          init_cmd <= ddr2_pkg::CMD_NOP;
          if (wait_cnt != '0) begin
            wait_cnt <= wait_cnt - 1'b1;
          end else if (step_last) begin
            init_end <= 1'b1;
            state    <= ddr2_pkg::INIT_DONE;
          end else begin
            step  <= step + 1'b1;
            state <= ddr2_pkg::INIT_ISSUE;
          end
        end
        default: state <= ddr2_pkg::INIT_DONE;
      endcase
    end
  end

endmodule

//--- logic/ddr2_refresh_timer.sv
// DDR2 refresh interval timer
module ddr2_refresh_timer (
  input  logic clk,
  input  logic rst_n,
  input  logic init_end,
  input  logic ref_ack,
  output logic ref_req
);

  typedef logic [$clog2(ddr2_pkg::T_REFI)-1:0] refi_cnt_t;

  refi_cnt_t refi_cnt;
  logic      refi_hit;

  assign refi_hit = init_end && (refi_cnt == refi_cnt_t'(ddr2_pkg::T_REFI - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      refi_cnt <= '0;
      ref_req  <= 1'b0;
    end else begin
      if (refi_hit) begin
        refi_cnt <= '0;
      end else if (init_end) begin
        refi_cnt <= refi_cnt + 1'b1;
      end
      // request stays up until the FSM takes it
      if (refi_hit) begin
        ref_req <= 1'b1;
      end else if (ref_ack) begin
        ref_req <= 1'b0;
      end
    end
  end

endmodule

//--- logic/ddr2_ctrl_fsm.sv
// DDR2 command control FSM
module ddr2_ctrl_fsm (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 init_end,
  input  ddr2_pkg::dram_cmd_t  init_cmd,
  input  ddr2_pkg::bank_t      init_ba,
  input  ddr2_pkg::dram_addr_t init_addr,
  input  logic                 ref_req,
  input  logic                 awvalid,
  input  ddr2_pkg::axi_addr_t  awaddr,
  input  ddr2_pkg::burst_len_t awlen,
  input  logic                 wvalid,
  input  logic                 bready,
  input  logic                 arvalid,
  input  ddr2_pkg::axi_addr_t  araddr,
  input  ddr2_pkg::burst_len_t arlen,
  output logic                 ref_ack,
  output logic                 awready,
  output logic                 wready,
  output logic                 bvalid,
  output logic                 arready,
  output ddr2_pkg::dram_cmd_t  dram_cmd,
  output ddr2_pkg::bank_t      dram_ba,
  output ddr2_pkg::dram_addr_t dram_addr,
  output logic                 wr_beat,
  output logic                 rd_issue,
  output logic                 rd_last_issue
);

  typedef logic [$clog2(ddr2_pkg::T_RFC)-1:0] wait_t;

  ddr2_pkg::ctrl_state_t state;
  ddr2_pkg::dram_cmd_t   cmd;
  ddr2_pkg::bank_t       ba;
  ddr2_pkg::dram_addr_t  addr;
  wait_t                 wait_cnt;
  logic                  rd_mode;
  ddr2_pkg::burst_len_t  beat_cnt;
  ddr2_pkg::burst_len_t  cmd_cnt;
  ddr2_pkg::col_t        col0;
  ddr2_pkg::burst_len_t  len;

  logic                  aw_go;
  logic                  ar_go;
  ddr2_pkg::axi_addr_t   acc_addr;
  ddr2_pkg::col_t        col_next;
  ddr2_pkg::dram_addr_t  prea_addr;
  logic                  last_read;

  // ----------------------------------------------------------------------
  // handshakes
  // ----------------------------------------------------------------------
  assign awready = (state == ddr2_pkg::ST_IDLE) && !ref_req && !bvalid;
  // writes win when both channels ask
  assign arready = (state == ddr2_pkg::ST_IDLE) && !ref_req && !awvalid;
  assign ref_ack = (state == ddr2_pkg::ST_IDLE) && ref_req;
  assign wready  = (state == ddr2_pkg::ST_WRITE);
  assign wr_beat = wready && wvalid;

  assign aw_go    = awready && awvalid;
  assign ar_go    = arready && arvalid;
  assign acc_addr = aw_go ? awaddr : araddr;

  // burst of four per column command
  assign col_next  = col0 + ddr2_pkg::col_t'({cmd_cnt, 2'b00});
  assign last_read = (cmd_cnt == (len >> 1));
  assign prea_addr = ddr2_pkg::dram_addr_t'(1) << ddr2_pkg::A10_ALLPRE;

  // init sequencer owns the bus until init_end
  assign dram_cmd  = (state == ddr2_pkg::ST_INIT) ? init_cmd  : cmd;
  assign dram_ba   = (state == ddr2_pkg::ST_INIT) ? init_ba   : ba;
  assign dram_addr = (state == ddr2_pkg::ST_INIT) ? init_addr : addr;

  // ----------------------------------------------------------------------
  // state machine and command register
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state         <= ddr2_pkg::ST_INIT;
      cmd           <= ddr2_pkg::CMD_NOP;
      ba            <= '0;
      addr          <= '0;
      wait_cnt      <= '0;
      rd_mode       <= 1'b0;
      beat_cnt      <= '0;
      cmd_cnt       <= '0;
      bvalid        <= 1'b0;
      rd_issue      <= 1'b0;
      rd_last_issue <= 1'b0;
    end else begin
      cmd           <= ddr2_pkg::CMD_NOP;
      rd_issue      <= 1'b0;
      rd_last_issue <= 1'b0;
      if (bvalid && bready) begin
        bvalid <= 1'b0;
      end
      case (state)
        ddr2_pkg::ST_INIT: begin
          if (init_end) begin
            state <= ddr2_pkg::ST_IDLE;
          end
        end
        ddr2_pkg::ST_IDLE: begin
          if (ref_req) begin
            cmd      <= ddr2_pkg::CMD_PRE;
            addr     <= prea_addr;
            wait_cnt <= wait_t'(ddr2_pkg::T_RP - 1);
            state    <= ddr2_pkg::ST_REF_PRE;
          end else if (aw_go || ar_go) begin
            cmd      <= ddr2_pkg::CMD_ACT;
            ba       <= acc_addr[ddr2_pkg::COL_BITS+ddr2_pkg::ROW_BITS +: ddr2_pkg::BA_BITS];
            addr     <= ddr2_pkg::dram_addr_t'(acc_addr[ddr2_pkg::COL_BITS +: ddr2_pkg::ROW_BITS]);
            rd_mode  <= !aw_go;
            beat_cnt <= '0;
            cmd_cnt  <= '0;
            // reads enter ST_READ a cycle early so the first READ lands on tRCD
            wait_cnt <= aw_go ? wait_t'(ddr2_pkg::T_RCD - 1) : wait_t'(ddr2_pkg::T_RCD - 2);
            state    <= ddr2_pkg::ST_ACT_WAIT;
          end
        end
        ddr2_pkg::ST_REF_PRE: begin
          if (wait_cnt == '0) begin
            cmd      <= ddr2_pkg::CMD_AREF;
            wait_cnt <= wait_t'(ddr2_pkg::T_RFC - 1);
            state    <= ddr2_pkg::ST_REF_WAIT;
          end else begin
            wait_cnt <= wait_cnt - 1'b1;
          end
        end
        ddr2_pkg::ST_REF_WAIT: begin
          if (wait_cnt == '0) begin
            state <= ddr2_pkg::ST_IDLE;
          end else begin
            wait_cnt <= wait_cnt - 1'b1;
          end
        end
        ddr2_pkg::ST_ACT_WAIT: begin
          if (wait_cnt == '0) begin
            state <= rd_mode ? ddr2_pkg::ST_READ : ddr2_pkg::ST_WRITE;
          end else begin
            wait_cnt <= wait_cnt - 1'b1;
          end
        end
        ddr2_pkg::ST_WRITE: begin
          if (wr_beat) begin
            beat_cnt <= beat_cnt + 1'b1;
            // odd beat completes a pair
            if (beat_cnt[0]) begin
              cmd     <= ddr2_pkg::CMD_WRITE;
              addr    <= ddr2_pkg::dram_addr_t'(col_next);
              cmd_cnt <= cmd_cnt + 1'b1;
            end
            if (beat_cnt == len) begin
              wait_cnt <= wait_t'(ddr2_pkg::WL + ddr2_pkg::T_WR);
              state    <= ddr2_pkg::ST_WR_RECOVER;
            end
          end
        end
        ddr2_pkg::ST_WR_RECOVER: begin
          if (wait_cnt == '0) begin
            cmd      <= ddr2_pkg::CMD_PRE;
            addr     <= prea_addr;
            bvalid   <= 1'b1;
            wait_cnt <= wait_t'(ddr2_pkg::T_RP - 1);
            state    <= ddr2_pkg::ST_PRE_WAIT;
          end else begin
            wait_cnt <= wait_cnt - 1'b1;
          end
        end
        ddr2_pkg::ST_READ: begin
          // one READ every second cycle
          if (cmd != ddr2_pkg::CMD_READ) begin
            cmd      <= ddr2_pkg::CMD_READ;
            addr     <= ddr2_pkg::dram_addr_t'(col_next);
            rd_issue <= 1'b1;
            cmd_cnt  <= cmd_cnt + 1'b1;
            if (last_read) begin
              rd_last_issue <= 1'b1;
              wait_cnt      <= wait_t'(ddr2_pkg::RL + 1);
              state         <= ddr2_pkg::ST_RD_DRAIN;
            end
          end
        end
        ddr2_pkg::ST_RD_DRAIN: begin
          if (wait_cnt == '0) begin
            cmd      <= ddr2_pkg::CMD_PRE;
            addr     <= prea_addr;
            wait_cnt <= wait_t'(ddr2_pkg::T_RP - 1);
            state    <= ddr2_pkg::ST_PRE_WAIT;
          end else begin
            wait_cnt <= wait_cnt - 1'b1;
          end
        end
        ddr2_pkg::ST_PRE_WAIT: begin
          if (wait_cnt == '0) begin
            state <= ddr2_pkg::ST_IDLE;
          end else begin
            wait_cnt <= wait_cnt - 1'b1;
          end
        end
        default: state <= ddr2_pkg::ST_IDLE;
      endcase
    end
  end

  // request fields held for the whole access
  always_ff @(posedge clk) begin
    if (aw_go || ar_go) begin
      col0 <= acc_addr[0 +: ddr2_pkg::COL_BITS];
      len  <= aw_go ? awlen : arlen;
    end
  end

endmodule

//--- logic/ddr2_wdata_path.sv
// DDR2 write data delay line
module ddr2_wdata_path (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            wr_beat,
  input  ddr2_pkg::word_t wdata,
  output ddr2_pkg::word_t dq_out,
  output logic            dq_oe
);

  // WL+1 stages, beat at t drives DQ at t+WL+1
  ddr2_pkg::word_t         data_q [ddr2_pkg::WL+1];
  logic [ddr2_pkg::WL:0]   valid_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else begin
      valid_q <= {valid_q[ddr2_pkg::WL-1:0], wr_beat};
    end
  end

  always_ff @(posedge clk) begin
    data_q[0] <= wdata;
    for (int i = 1; i <= ddr2_pkg::WL; i++) begin
      data_q[i] <= data_q[i-1];
    end
  end

  assign dq_out = data_q[ddr2_pkg::WL];
  assign dq_oe  = valid_q[ddr2_pkg::WL];

endmodule

//--- logic/ddr2_rdata_path.sv
// DDR2 read data capture
module ddr2_rdata_path (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            rd_issue,
  input  logic            rd_last_issue,
  input  ddr2_pkg::word_t dq_in,
  output logic            rvalid,
  output logic            rlast,
  output ddr2_pkg::word_t rdata
);

  // bit i is high i+1 cycles after the READ
  logic [ddr2_pkg::RL+1:0] rd_sh;
  logic [ddr2_pkg::RL+1:0] last_sh;
  logic                    capture;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_sh   <= '0;
      last_sh <= '0;
    end else begin
      rd_sh   <= {rd_sh[ddr2_pkg::RL:0], rd_issue};
      last_sh <= {last_sh[ddr2_pkg::RL:0], rd_last_issue};
    end
  end

  // dq_in carries the two words RL and RL+1 cycles after the READ
  assign capture = rd_sh[ddr2_pkg::RL-1] | rd_sh[ddr2_pkg::RL];

  always_ff @(posedge clk) begin
    if (capture) begin
      rdata <= dq_in;
    end
  end

  assign rvalid = rd_sh[ddr2_pkg::RL] | rd_sh[ddr2_pkg::RL+1];
  // second word of the final READ
  assign rlast  = last_sh[ddr2_pkg::RL+1];

endmodule

//--- logic/ddr2_ctrl_top.sv
// DDR2 command controller top
module ddr2_ctrl_top (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 awvalid,
  output logic                 awready,
  input  ddr2_pkg::axi_addr_t  awaddr,
  input  ddr2_pkg::burst_len_t awlen,
  input  logic                 wvalid,
  output logic                 wready,
  input  ddr2_pkg::word_t      wdata,
  output logic                 bvalid,
  input  logic                 bready,
  input  logic                 arvalid,
  output logic                 arready,
  input  ddr2_pkg::axi_addr_t  araddr,
  input  ddr2_pkg::burst_len_t arlen,
  output logic                 rvalid,
  output logic                 rlast,
  output ddr2_pkg::word_t      rdata,
  output ddr2_pkg::dram_cmd_t  dram_cmd,
  output ddr2_pkg::bank_t      dram_ba,
  output ddr2_pkg::dram_addr_t dram_addr,
  output logic                 dram_cke,
  output ddr2_pkg::word_t      dq_out,
  output logic                 dq_oe,
  input  ddr2_pkg::word_t      dq_in,
  output logic                 init_end
);

  ddr2_pkg::dram_cmd_t  init_cmd;
  ddr2_pkg::bank_t      init_ba;
  ddr2_pkg::dram_addr_t init_addr;
  logic                 ref_req;
  logic                 ref_ack;
  logic                 wr_beat;
  logic                 rd_issue;
  logic                 rd_last_issue;

  // ----------------------------------------------------------------------
  // control
  // ----------------------------------------------------------------------
  ddr2_init_seq init_seq_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .init_cmd  (init_cmd),
    .init_ba   (init_ba),
    .init_addr (init_addr),
    .dram_cke  (dram_cke),
    .init_end  (init_end)
  );

  ddr2_refresh_timer refresh_timer_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .init_end (init_end),
    .ref_ack  (ref_ack),
    .ref_req  (ref_req)
  );

  ddr2_ctrl_fsm ctrl_fsm_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .init_end      (init_end),
    .init_cmd      (init_cmd),
    .init_ba       (init_ba),
    .init_addr     (init_addr),
    .ref_req       (ref_req),
    .awvalid       (awvalid),
    .awaddr        (awaddr),
    .awlen         (awlen),
    .wvalid        (wvalid),
    .bready        (bready),
    .arvalid       (arvalid),
    .araddr        (araddr),
    .arlen         (arlen),
    .ref_ack       (ref_ack),
    .awready       (awready),
    .wready        (wready),
    .bvalid        (bvalid),
    .arready       (arready),
    .dram_cmd      (dram_cmd),
    .dram_ba       (dram_ba),
    .dram_addr     (dram_addr),
    .wr_beat       (wr_beat),
    .rd_issue      (rd_issue),
    .rd_last_issue (rd_last_issue)
  );

  // ----------------------------------------------------------------------
  // datapath
  // ----------------------------------------------------------------------
  ddr2_wdata_path wdata_path_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr_beat (wr_beat),
    .wdata   (wdata),
    .dq_out  (dq_out),
    .dq_oe   (dq_oe)
  );

  ddr2_rdata_path rdata_path_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .rd_issue      (rd_issue),
    .rd_last_issue (rd_last_issue),
    .dq_in         (dq_in),
    .rvalid        (rvalid),
    .rlast         (rlast),
    .rdata         (rdata)
  );

endmodule

//--- testbench/tb_ddr2_model.svh
// DDR2 testbench model
`ifndef TB_DDR2_MODEL_SVH
`define TB_DDR2_MODEL_SVH

logic [31:0] lfsr_state = 32'hcc9b_2414;

ddr2_pkg::word_t     mem [int];
ddr2_pkg::word_t     dq_sched [int];
ddr2_pkg::axi_addr_t acc_q [$];
ddr2_pkg::word_t     wdata_q [$];
ddr2_pkg::word_t     wstore_q [$];
int                  wkey_q [$];
ddr2_pkg::word_t     rdata_q [$];

// open row tracking
logic                row_open = 1'b0;
ddr2_pkg::bank_t     cur_bank;
ddr2_pkg::row_t      cur_row;
ddr2_pkg::col_t      cur_col0;
int                  col_k;
ddr2_pkg::dram_cmd_t last_cmd = ddr2_pkg::CMD_NOP;
int                  init_idx = 0;
logic                init_seen = 1'b0;
int                  last_aref_cyc;

// Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] r;
  logic        fb;
  r = '0;
  for (int i = 0; i < n; i++) begin
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    r = {r[30:0], fb};
  end
  return r;
endfunction

function automatic int mem_key(input ddr2_pkg::bank_t b, input ddr2_pkg::row_t r,
                               input ddr2_pkg::col_t c);
  return int'({b, r, c});
endfunction

// unwritten locations read back a pattern of the full address
function automatic ddr2_pkg::word_t read_mem(input int key);
  logic [25:0] k;
  k = key[25:0];
  if (mem.exists(key)) begin
    return mem[key];
  end
  return ddr2_pkg::word_t'(k[15:0] ^ {k[25:16], k[25:20]});
endfunction

function automatic ddr2_pkg::dram_cmd_t init_cmd_at(input int i);
  case (i)
    0, 5:    return ddr2_pkg::CMD_PRE;
    6, 7:    return ddr2_pkg::CMD_AREF;
    default: return ddr2_pkg::CMD_LMR;
  endcase
endfunction

function automatic ddr2_pkg::bank_t init_bank_at(input int i);
  case (i)
    1:       return ddr2_pkg::bank_t'(2);
    2:       return ddr2_pkg::bank_t'(3);
    3:       return ddr2_pkg::bank_t'(1);
    default: return ddr2_pkg::bank_t'(0);
  endcase
endfunction

// ----------------------------------------------------------------------
// compare tasks
// ----------------------------------------------------------------------
task automatic stop_run(input string what);
  $display("%s", what);
  $display("Something failed");
  $fatal(1, "simulation stopped");
endtask

task automatic check_cmd(input string name, input ddr2_pkg::dram_cmd_t expected,
                         input ddr2_pkg::dram_cmd_t actual);
  if (actual !== expected) begin
    stop_run($sformatf("** Error at %0t: %s expected %s, got %s",
                       $time, name, expected.name(), actual.name()));
  end
endtask

task automatic check_word(input string name, input ddr2_pkg::word_t expected,
                          input ddr2_pkg::word_t actual);
  if (actual !== expected) begin
    stop_run($sformatf("** Error at %0t: %s expected %h, got %h",
                       $time, name, expected, actual));
  end
endtask

task automatic check_bank(input string name, input ddr2_pkg::bank_t expected,
                          input ddr2_pkg::bank_t actual);
  if (actual !== expected) begin
    stop_run($sformatf("** Error at %0t: %s expected %h, got %h",
                       $time, name, expected, actual));
  end
endtask

task automatic check_addr(input string name, input ddr2_pkg::dram_addr_t expected,
                          input ddr2_pkg::dram_addr_t actual);
  if (actual !== expected) begin
    stop_run($sformatf("** Error at %0t: %s expected %h, got %h",
                       $time, name, expected, actual));
  end
endtask

task automatic check_flag(input string name, input logic expected, input logic actual);
  if (actual !== expected) begin
    stop_run($sformatf("** Error at %0t: %s expected %b, got %b",
                       $time, name, expected, actual));
  end
endtask

`endif

//--- testbench/tb_ddr2_ctrl.sv
// DDR2 controller testbench
module tb_ddr2_ctrl;

  localparam int N_TRANS         = 20;
  localparam int INIT_CYCLES     = 100;
  localparam int MAX_ACCESS      = 80;
  localparam int WATCHDOG_CYCLES = (ddr2_pkg::T_REFI * N_TRANS + INIT_CYCLES) * 2;

  logic                 clk;
  logic                 rst_n;
  logic                 awvalid;
  logic                 awready;
  ddr2_pkg::axi_addr_t  awaddr;
  ddr2_pkg::burst_len_t awlen;
  logic                 wvalid;
  logic                 wready;
  ddr2_pkg::word_t      wdata;
  logic                 bvalid;
  logic                 bready;
  logic                 arvalid;
  logic                 arready;
  ddr2_pkg::axi_addr_t  araddr;
  ddr2_pkg::burst_len_t arlen;
  logic                 rvalid;
  logic                 rlast;
  ddr2_pkg::word_t      rdata;
  ddr2_pkg::dram_cmd_t  dram_cmd;
  ddr2_pkg::bank_t      dram_ba;
  ddr2_pkg::dram_addr_t dram_addr;
  logic                 dram_cke;
  ddr2_pkg::word_t      dq_out;
  logic                 dq_oe;
  ddr2_pkg::word_t      dq_in;
  logic                 init_end;

  int   cyc = 0;
  int   rd_total = 0;
  int   rd_seen = 0;
  int   n_writes = 0;
  int   b_rises = 0;
  int   cke_low_cyc = 0;
  logic bvalid_d = 1'b0;

  ddr2_pkg::dram_addr_t prea_word;

  `include "tb_ddr2_model.svh"

  ddr2_ctrl_top dut_i (.*);

  assign prea_word = ddr2_pkg::dram_addr_t'(1) << ddr2_pkg::A10_ALLPRE;

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  // read data from the memory model
  always @(posedge clk) begin
    #2;
    if (dq_sched.exists(cyc)) begin
      dq_in = dq_sched[cyc];
    end else begin
      dq_in = '0;
    end
  end

  // ----------------------------------------------------------------------
  // command and data monitor
  // ----------------------------------------------------------------------
  task automatic track_cmd();
    ddr2_pkg::axi_addr_t a;
    ddr2_pkg::col_t      c;
    ddr2_pkg::word_t     w;
    int                  key;
    if (!init_seen) begin
      if (init_idx != 9) begin
        stop_run("init ended before all nine init commands were issued");
      end
      init_seen     = 1'b1;
      last_aref_cyc = cyc;
    end
    case (dram_cmd)
      ddr2_pkg::CMD_ACT: begin
        if (row_open) stop_run("ACT issued while a row was still open");
        if (acc_q.size() == 0) stop_run("ACT issued with no accepted address");
        a = acc_q.pop_front();
        cur_bank = a[25:23];
        cur_row  = a[22:10];
        cur_col0 = a[9:0];
        col_k    = 0;
        row_open = 1'b1;
        check_bank("dram_ba", cur_bank, dram_ba);
        check_addr("dram_addr", ddr2_pkg::dram_addr_t'(cur_row), dram_addr);
      end
      ddr2_pkg::CMD_WRITE, ddr2_pkg::CMD_READ: begin
        if (!row_open) stop_run("column command issued with no open row");
        c = cur_col0 + ddr2_pkg::col_t'(4 * col_k);
        col_k++;
        check_addr("dram_addr", ddr2_pkg::dram_addr_t'(c), dram_addr);
        for (int j = 0; j < 2; j++) begin
          key = mem_key(cur_bank, cur_row, c + ddr2_pkg::col_t'(j));
          if (dram_cmd == ddr2_pkg::CMD_WRITE) begin
            wkey_q.push_back(key);
          end else begin
            w = read_mem(key);
            rdata_q.push_back(w);
            dq_sched[cyc + ddr2_pkg::RL + j] = w;
          end
        end
      end
      ddr2_pkg::CMD_PRE: begin
        check_addr("dram_addr", prea_word, dram_addr);
        row_open = 1'b0;
      end
      ddr2_pkg::CMD_AREF: begin
        if (last_cmd != ddr2_pkg::CMD_PRE) stop_run("AREF without a PRE just before it");
        if (cyc - last_aref_cyc > ddr2_pkg::T_REFI + MAX_ACCESS) begin
          stop_run("refresh interval exceeded");
        end
        last_aref_cyc = cyc;
      end
      ddr2_pkg::CMD_NOP: begin
      end
      default: stop_run("unexpected command after init");
    endcase
    if (dram_cmd != ddr2_pkg::CMD_NOP) begin
      last_cmd = dram_cmd;
    end
  endtask

  task automatic track_init();
    if (dram_cmd == ddr2_pkg::CMD_NOP) begin
      if (init_idx == 0 && !dram_cke) cke_low_cyc++;
    end else begin
      if (init_idx >= 9) stop_run("more than nine commands during init");
      if (init_idx == 0) begin
        check_flag("dram_cke", 1'b1, dram_cke);
        if (cke_low_cyc < ddr2_pkg::T_CKE_WAIT) begin
          stop_run("CKE rose before the power-up wait ended");
        end
      end
      check_cmd("dram_cmd", init_cmd_at(init_idx), dram_cmd);
      if (dram_cmd == ddr2_pkg::CMD_LMR) begin
        check_bank("dram_ba", init_bank_at(init_idx), dram_ba);
      end
      if (dram_cmd == ddr2_pkg::CMD_PRE) begin
        check_addr("dram_addr", prea_word, dram_addr);
      end
      init_idx++;
    end
  endtask

  always @(negedge clk) begin
    if (rst_n) begin
      if (awvalid && awready) acc_q.push_back(awaddr);
      if (arvalid && arready) acc_q.push_back(araddr);
      if (wvalid && wready) wdata_q.push_back(wdata);
      if (dq_oe) begin
        if (wdata_q.size() == 0) stop_run("DQ driven with no write data pending");
        check_word("dq_out", wdata_q.pop_front(), dq_out);
        wstore_q.push_back(dq_out);
      end
      if (rvalid) begin
        if (rdata_q.size() == 0) stop_run("rvalid high with no read outstanding");
        rd_seen++;
        check_word("rdata", rdata_q.pop_front(), rdata);
        check_flag("rlast", rd_seen == rd_total, rlast);
      end
      if (bvalid && !bvalid_d) b_rises++;
      bvalid_d = bvalid;
      if (!init_end) begin
        track_init();
      end else begin
        track_cmd();
      end
      // pair write keys with DQ words in order
      while (wkey_q.size() != 0 && wstore_q.size() != 0) begin
        mem[wkey_q.pop_front()] = wstore_q.pop_front();
      end
    end
  end

  // ----------------------------------------------------------------------
  // stimulus
  // ----------------------------------------------------------------------
  task automatic write_burst(input ddr2_pkg::axi_addr_t a, input ddr2_pkg::burst_len_t len);
    int              taken;
    int              hold;
    ddr2_pkg::word_t d;
    @(posedge clk);
    #2;
    awvalid = 1'b1;
    awaddr  = a;
    awlen   = len;
    do @(negedge clk); while (!awready);
    @(posedge clk);
    #2;
    awvalid = 1'b0;
    taken   = 0;
    d       = ddr2_pkg::word_t'(rand_bits(16));
    while (taken <= int'(len)) begin
      if (rand_bits(3) == 0) begin
        wvalid = 1'b0;
      end else begin
        wvalid = 1'b1;
        wdata  = d;
      end
      @(negedge clk);
      if (wvalid && wready) begin
        taken++;
        d = ddr2_pkg::word_t'(rand_bits(16));
      end
      @(posedge clk);
      #2;
    end
    wvalid = 1'b0;
    do @(negedge clk); while (!bvalid);
    hold = int'(rand_bits(2));
    repeat (hold) @(posedge clk);
    @(posedge clk);
    #2;
    bready = 1'b1;
    @(posedge clk);
    #2;
    bready = 1'b0;
    @(negedge clk);
    check_flag("bvalid", 1'b0, bvalid);
    n_writes++;
  endtask

  task automatic read_burst(input ddr2_pkg::axi_addr_t a, input ddr2_pkg::burst_len_t len);
    rd_total = int'(len) + 1;
    rd_seen  = 0;
    @(posedge clk);
    #2;
    arvalid = 1'b1;
    araddr  = a;
    arlen   = len;
    do @(negedge clk); while (!arready);
    @(posedge clk);
    #2;
    arvalid = 1'b0;
    do @(negedge clk); while (rd_seen < rd_total);
  endtask

  initial begin
    ddr2_pkg::axi_addr_t  a;
    ddr2_pkg::burst_len_t len;
    rst_n   = 1'b0;
    awvalid = 1'b0;
    awaddr  = '0;
    awlen   = '0;
    wvalid  = 1'b0;
    wdata   = '0;
    bready  = 1'b0;
    arvalid = 1'b0;
    araddr  = '0;
    arlen   = '0;
    dq_in   = '0;
    repeat (10) @(posedge clk);
    #2;
    rst_n = 1'b1;
    @(negedge clk);
    check_cmd("dram_cmd", ddr2_pkg::CMD_NOP, dram_cmd);
    check_flag("awready", 1'b0, awready);
    check_flag("arready", 1'b0, arready);
    check_flag("wready", 1'b0, wready);
    check_flag("bvalid", 1'b0, bvalid);
    check_flag("rvalid", 1'b0, rvalid);
    check_flag("dq_oe", 1'b0, dq_oe);
    check_flag("dram_cke", 1'b0, dram_cke);
    check_flag("init_end", 1'b0, init_end);
    do @(negedge clk); while (!init_end);
    for (int n = 0; n < N_TRANS; n++) begin
      a   = ddr2_pkg::axi_addr_t'(rand_bits(26));
      len = ddr2_pkg::burst_len_t'(rand_bits(3) * 2 + 1);
      // mostly write then read back, sometimes a read of untouched memory
      if (rand_bits(2) != 0) begin
        write_burst(a, len);
        read_burst(a, len);
      end else begin
        read_burst(a, len);
      end
    end
    repeat (4) @(negedge clk);
    if (cyc - last_aref_cyc > ddr2_pkg::T_REFI + MAX_ACCESS) begin
      stop_run("no refresh issued within the refresh interval");
    end
    if (rdata_q.size() != 0 || wdata_q.size() != 0 || acc_q.size() != 0 ||
        b_rises != n_writes) begin
      stop_run("transfers left unbalanced at the end of the test");
    end else begin
      $display("Everything OK");
      $finish;
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    stop_run("watchdog timeout, the test did not finish in time");
  end

endmodule

//--- sources.f
+incdir+testbench
logic/ddr2_pkg.sv
logic/ddr2_init_seq.sv
logic/ddr2_refresh_timer.sv
logic/ddr2_ctrl_fsm.sv
logic/ddr2_wdata_path.sv
logic/ddr2_rdata_path.sv
logic/ddr2_ctrl_top.sv
testbench/tb_ddr2_ctrl.sv
